//--- logic/uart_params.svh
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// serial timing
// clock cycles spent on each bit of a frame
`define UART_CLKS_PER_BIT 8

// bus geometry
// word address into the register map
`define UART_ADR_W 4
// bus data word
`define UART_DAT_W 32

// register map, word offsets
// data: write sends a byte, read pops the rx buffer
`define UART_REG_DATA 0
// status: read-only flags, read clears overrun and frame error
`define UART_REG_STATUS 1

`endif

//--- logic/uart_pkg.sv
`default_nettype none

`include "uart_params.svh"

package uart_pkg;

  // one serial character
  typedef logic [7:0] byte_t;

  // bus words
  typedef logic [`UART_ADR_W-1:0] wb_adr_t;
  typedef logic [`UART_DAT_W-1:0] wb_dat_t;

  // index of the data bit within a frame
  typedef logic [2:0] bit_cnt_t;
  // must reach UART_CLKS_PER_BIT itself, hence the +1
  typedef logic [$clog2(`UART_CLKS_PER_BIT + 1)-1:0] baud_cnt_t;

  // status word, low four bits, rx_full on top
  typedef struct packed {
    logic rx_full;
    logic tx_busy;
    logic overrun;
    logic frame_error;
  } uart_status_t;

  // wishbone classic master side
  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    wb_dat_t dat_w;
  } wb_req_t;

  // wishbone classic slave side
  typedef struct packed {
    logic    ack;
    wb_dat_t dat_r;
  } wb_rsp_t;

  // one finished frame from the receiver
  typedef struct packed {
    logic  valid;
    byte_t data;
    logic  frame_ok;
  } rx_byte_t;

  // serializer phases
  typedef enum logic [1:0] {
    tx_st_idle,
    tx_st_start,
    tx_st_data,
    tx_st_stop
  } tx_state_e;

  // deserializer phases
  typedef enum logic [1:0] {
    rx_st_idle,
    rx_st_start,
    rx_st_data,
    rx_st_stop
  } rx_state_e;

endpackage

`default_nettype wire

//--- logic/uart_tx.sv
`default_nettype none

`include "uart_params.svh"

module uart_tx
  import uart_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  tx_start,
  input  byte_t tx_data,
  output logic  txd,
  output logic  tx_busy
);

  tx_state_e state;
  baud_cnt_t baud_cnt;
  bit_cnt_t  bit_cnt;
  byte_t     shreg;
  logic      bit_end;

  // last clock of the current bit period
  assign bit_end = (baud_cnt == baud_cnt_t'(`UART_CLKS_PER_BIT - 1));

  // busy for the whole frame, start bit through stop bit
  assign tx_busy = (state != tx_st_idle);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= tx_st_idle;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      txd      <= 1'b1;
    end else begin
      // free-running within a bit, restarted at each bit edge
      if (state == tx_st_idle || bit_end) begin
        baud_cnt <= '0;
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
      case (state)
        tx_st_idle: begin
          // start pulses while busy never reach this branch
          if (tx_start) begin
            state   <= tx_st_start;
            txd     <= 1'b0;
            bit_cnt <= '0;
          end
        end
        tx_st_start: begin
          if (bit_end) begin
            state <= tx_st_data;
            // lsb goes out first
            txd   <= shreg[0];
          end
        end
        tx_st_data: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == bit_cnt_t'(7)) begin
              state <= tx_st_stop;
              txd   <= 1'b1;
            end else begin
              txd <= shreg[1];
            end
          end
        end
        default: begin
          // stop bit, line stays high afterwards
          if (bit_end) begin
            state <= tx_st_idle;
          end
        end
      endcase
    end
  end

  // byte latched on start, then shifted right once per data bit
  always_ff @(posedge clk) begin
    if (state == tx_st_idle && tx_start) begin
      shreg <= tx_data;
    end else if (state == tx_st_data && bit_end) begin
      shreg <= {1'b0, shreg[7:1]};
    end
  end

endmodule

`default_nettype wire

//--- logic/uart_rx.sv
`default_nettype none

`include "uart_params.svh"

module uart_rx
  import uart_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     rxd,
  output rx_byte_t rx_out
);

  rx_state_e state;
  baud_cnt_t baud_cnt;
  bit_cnt_t  bit_cnt;
  byte_t     shreg;
  logic      rxd_meta;
  logic      rxd_sync;
  logic      rxd_prev;
  logic      fall;
  logic      half_bit;
  logic      full_bit;

  // two-flop synchronizer plus one more stage for edge detect
  always_ff @(posedge clk) begin
    if (rst) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  // high to low on the synchronized line
  assign fall = rxd_prev & ~rxd_sync;

  // middle of the start bit, counted from the edge
  assign half_bit = (baud_cnt == baud_cnt_t'(`UART_CLKS_PER_BIT / 2 - 1));
  // one bit later, middle of the next bit
  assign full_bit = (baud_cnt == baud_cnt_t'(`UART_CLKS_PER_BIT - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= rx_st_idle;
      baud_cnt     <= '0;
      bit_cnt      <= '0;
      rx_out.valid <= 1'b0;
    end else begin
      // valid is a single-cycle pulse
      rx_out.valid <= 1'b0;
      baud_cnt     <= baud_cnt + 1'b1;
      case (state)
        rx_st_idle: begin
          baud_cnt <= '0;
          if (fall) begin
            state <= rx_st_start;
          end
        end
        rx_st_start: begin
          if (half_bit) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            // glitch, line already back high
            if (rxd_sync) begin
              state <= rx_st_idle;
            end else begin
              state <= rx_st_data;
            end
          end
        end
        rx_st_data: begin
          if (full_bit) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == bit_cnt_t'(7)) begin
              state <= rx_st_stop;
            end
          end
        end
        default: begin
          // stop sample decides frame_ok, overflow is judged upstream
          if (full_bit) begin
            state           <= rx_st_idle;
            rx_out.valid    <= 1'b1;
            rx_out.data     <= shreg;
            rx_out.frame_ok <= rxd_sync;
          end
        end
      endcase
    end
  end

  // lsb arrives first, so shift in from the top
  always_ff @(posedge clk) begin
    if (state == rx_st_data && full_bit) begin
      shreg <= {rxd_sync, shreg[7:1]};
    end
  end

endmodule

`default_nettype wire

//--- logic/uart_regs.sv
`default_nettype none

`include "uart_params.svh"

module uart_regs
  import uart_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  wb_req_t  wb_req,
  output wb_rsp_t  wb_rsp,
  output logic     tx_start,
  output byte_t    tx_data,
  input  logic     tx_busy,
  input  rx_byte_t rx_in
);

  wb_rsp_t      rsp_q;
  uart_status_t status;
  byte_t        rx_buf;
  logic         rx_full_q;
  logic         overrun_q;
  logic         frame_err_q;
  logic         req;
  logic         is_data;
  logic         is_status;
  logic         wr_data_go;
  logic         rd_data_go;
  logic         rd_stat_go;
  logic         other_go;

  // live status view, tx_busy straight from the serializer
  always_comb begin
    status.rx_full     = rx_full_q;
    status.tx_busy     = tx_busy;
    status.overrun     = overrun_q;
    status.frame_error = frame_err_q;
  end

  // pending access, not yet acked
  assign req       = wb_req.cyc & wb_req.stb & ~rsp_q.ack;
  assign is_data   = (wb_req.adr == wb_adr_t'(`UART_REG_DATA));
  assign is_status = (wb_req.adr == wb_adr_t'(`UART_REG_STATUS));

  // data write stalls while a frame is on the line
  assign wr_data_go = req & wb_req.we & is_data & ~tx_busy;
  // data read stalls until a byte sits in the buffer
  assign rd_data_go = req & ~wb_req.we & is_data & rx_full_q;
  assign rd_stat_go = req & ~wb_req.we & is_status;
  // status writes and unmapped offsets ack at once
  assign other_go   = req & ~is_data;

  assign wb_rsp   = rsp_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_q       <= '0;
      tx_start    <= 1'b0;
      rx_full_q   <= 1'b0;
      overrun_q   <= 1'b0;
      frame_err_q <= 1'b0;
    end else begin
      rsp_q.ack   <= wr_data_go | rd_data_go | other_go;
      // start pulse lines up with the write ack
      tx_start    <= wr_data_go;
      // read data is zero unless a read is acked
      rsp_q.dat_r <= '0;
      if (rd_data_go) begin
        rsp_q.dat_r <= wb_dat_t'(rx_buf);
        rx_full_q   <= 1'b0;
      end
      if (rd_stat_go) begin
        rsp_q.dat_r <= wb_dat_t'(status);
        overrun_q   <= 1'b0;
        frame_err_q <= 1'b0;
      end
      // incoming frame, placed last so a new event beats the clear
      if (rx_in.valid) begin
        if (!rx_in.frame_ok) begin
          frame_err_q <= 1'b1;
        end else if (rx_full_q && !rd_data_go) begin
          // buffer still held, new byte is lost
          overrun_q <= 1'b1;
        end else begin
          rx_full_q <= 1'b1;
        end
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (wr_data_go) begin
      tx_data <= wb_req.dat_w[7:0];
    end
    // a byte taken in the same cycle as a pop refills the buffer
    if (rx_in.valid && rx_in.frame_ok && (!rx_full_q || rd_data_go)) begin
      rx_buf <= rx_in.data;
    end
  end

endmodule

`default_nettype wire

//--- logic/uart_periph.sv
`default_nettype none

module uart_periph
  import uart_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp,
  input  logic    rxd,
  output logic    txd
);

  // register block to serializer
  logic     tx_start;
  byte_t    tx_data;
  logic     tx_busy;
  // deserializer to register block
  rx_byte_t rx_byte;

  // bus side, rx buffer and flags
  uart_regs u_regs (
    .clk      (clk),
    .rst      (rst),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx_busy  (tx_busy),
    .rx_in    (rx_byte)
  );

  // transmit path
  uart_tx u_tx (
    .clk      (clk),
    .rst      (rst),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .txd      (txd),
    .tx_busy  (tx_busy)
  );

  // receive path
  uart_rx u_rx (
    .clk    (clk),
    .rst    (rst),
    .rxd    (rxd),
    .rx_out (rx_byte)
  );

endmodule

`default_nettype wire

//--- dv/uart_checker.sv
`default_nettype none

`include "uart_params.svh"

module uart_checker
  import uart_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  wb_req_t wb_req,
  input  wb_rsp_t wb_rsp,
  input  logic    txd,
  input  logic    rxd,
  output int      checks,
  output int      errors,
  output logic    tx_idle
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int cpb = `UART_CLKS_PER_BIT;

  // bytes written but not yet seen on txd
  byte_t   exp_tx[$];
  // one-byte receive buffer and sticky flags of the model
  logic    model_full;
  logic    model_overrun;
  logic    model_frame_err;
  byte_t   model_byte;
  // line decoders with txd at index 0 and rxd at index 1
  int      cnt[2];
  logic    active[2];
  logic    prev[2];
  byte_t   shift[2];
  // access that the next ack belongs to
  wb_req_t last_req;
  logic    last_pend;
  logic    after_rst;

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      $display("CHECK FAILED t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR t=%0t %s", $time, what);
  endtask

  // end of a frame as seen at the middle of its stop bit
  task automatic frame_done(input int ch, input byte_t data, input logic stop);
    byte_t exp_b;
    if (ch == 0) begin
      check_val("txd stop bit", 32'h1, 32'(stop));
      if (exp_tx.size() == 0) begin
        report_error("frame on txd without a data write");
      end else begin
        exp_b = exp_tx.pop_front();
        check_val("txd byte", 32'(exp_b), 32'(data));
      end
    end else if (!stop) begin
      model_frame_err = 1'b1;
    end else if (model_full) begin
      // buffer still held so the byte is lost
      model_overrun = 1'b1;
    end else begin
      model_full = 1'b1;
      model_byte = data;
    end
  endtask

  // mid-bit decoder whose count is zero at the first low sample
  task automatic step_line(input int ch, input logic val);
    int bit_idx;
    if (!active[ch]) begin
      if (prev[ch] && !val) begin
        active[ch] = 1'b1;
        cnt[ch]    = 0;
      end
    end else begin
      cnt[ch] = cnt[ch] + 1;
    end
    if (active[ch] && (cnt[ch] % cpb == cpb / 2 - 1)) begin
      bit_idx = cnt[ch] / cpb;
      if (bit_idx == 0) begin
        if (ch == 0) begin
          check_val("txd start bit", 32'h0, 32'(val));
        end
        // start bit gone by mid-bit so hunt again
        if (val) begin
          active[ch] = 1'b0;
        end
      end else if (bit_idx <= 8) begin
        shift[ch] = {val, shift[ch][7:1]};
      end else begin
        frame_done(ch, shift[ch], val);
      end
    end
    // frame over once the last stop sample has gone by
    if (active[ch] && cnt[ch] == 10 * cpb) begin
      active[ch] = 1'b0;
    end
    prev[ch] = val;
  endtask

  task automatic handle_ack();
    logic [31:0] exp_stat;
    logic        busy;
    busy = active[0] || (exp_tx.size() != 0);
    if (!last_pend) begin
      report_error("ack with no access pending");
    end else if (last_req.adr == wb_adr_t'(`UART_REG_DATA)) begin
      if (last_req.we) begin
        // the previous frame has to be fully out first
        if (busy) begin
          report_error("data write acked while the transmitter was busy");
        end
        exp_tx.push_back(last_req.dat_w[7:0]);
      end else if (!model_full) begin
        report_error("data read acked with an empty receive buffer");
      end else begin
        check_val("dat_r data", 32'(model_byte), wb_rsp.dat_r);
        model_full = 1'b0;
      end
    end else if (!last_req.we) begin
      exp_stat = '0;
      if (last_req.adr == wb_adr_t'(`UART_REG_STATUS)) begin
        exp_stat = {28'h0, model_full, busy, model_overrun, model_frame_err};
        model_overrun   = 1'b0;
        model_frame_err = 1'b0;
      end
      check_val("dat_r status or unmapped", exp_stat, wb_rsp.dat_r);
    end
  endtask

  // everything sampled on the rising edge before the DUT updates
  always @(posedge clk) begin
    if (rst) begin
      exp_tx.delete();
      model_full      = 1'b0;
      model_overrun   = 1'b0;
      model_frame_err = 1'b0;
      active          = '{1'b0, 1'b0};
      prev            = '{1'b1, 1'b1};
      last_pend       = 1'b0;
      after_rst       = 1'b1;
      checks          = 0;
      errors          = 0;
      tx_idle         = 1'b1;
    end else begin
      if (after_rst) begin
        check_val("txd after reset", 32'h1, 32'(txd));
        check_val("ack after reset", 32'h0, 32'(wb_rsp.ack));
        after_rst = 1'b0;
      end
      if (wb_rsp.ack) begin
        handle_ack();
      end
      step_line(0, txd);
      step_line(1, rxd);
      last_pend = wb_req.cyc & wb_req.stb;
      last_req  = wb_req;
      tx_idle   = (exp_tx.size() == 0) && !active[0];
    end
  end

endmodule

`default_nettype wire

//--- dv/tb_uart.sv
`default_nettype none

`include "uart_params.svh"

module tb_uart
  import uart_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int cpb = `UART_CLKS_PER_BIT;
  // 20 tx, 20 rx, 1 stalled read, 2 overrun, 2 framing
  localparam int num_frames = 45;
  localparam int max_cycles = num_frames * 10 * cpb * 2 + 1000;
  localparam wb_adr_t adr_data = `UART_REG_DATA;
  localparam wb_adr_t adr_status = `UART_REG_STATUS;
  localparam wb_adr_t adr_unmapped = 3;

  logic        clk;
  logic        rst;
  logic        rxd;
  logic        txd;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  int          n_checks;
  int          n_errors;
  int          err_mark;
  logic        tx_idle;
  logic [15:0] lfsr;
  int          cycles = 0;

  uart_periph DUT (
    .clk    (clk),
    .rst    (rst),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .rxd    (rxd),
    .txd    (txd)
  );

  uart_checker chk (
    .clk     (clk),
    .rst     (rst),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .txd     (txd),
    .rxd     (rxd),
    .checks  (n_checks),
    .errors  (n_errors),
    .tx_idle (tx_idle)
  );

  always #2 clk = ~clk;

  // run limit scaled from the number of frames
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: no finish within %0d cycles", max_cycles);
      $display("Test failures found");
      $finish;
    end
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
    end
    return v;
  endfunction

  // hold the request until ack and release it on the same falling edge
  task automatic finish_access();
    @(negedge clk);
    while (!wb_rsp.ack) begin
      @(negedge clk);
    end
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic bus_write(input wb_adr_t adr, input wb_dat_t dat);
    wb_req.cyc   = 1'b1;
    wb_req.stb   = 1'b1;
    wb_req.we    = 1'b1;
    wb_req.adr   = adr;
    wb_req.dat_w = dat;
    finish_access();
  endtask

  task automatic bus_read(input wb_adr_t adr);
    wb_req.cyc   = 1'b1;
    wb_req.stb   = 1'b1;
    wb_req.we    = 1'b0;
    wb_req.adr   = adr;
    wb_req.dat_w = '0;
    finish_access();
  endtask

  // one frame on rxd plus a bit of idle with a selectable stop level
  task automatic send_frame(input byte_t b, input logic stop);
    rxd = 1'b0;
    repeat (cpb) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      rxd = b[i];
      repeat (cpb) @(negedge clk);
    end
    rxd = stop;
    repeat (cpb) @(negedge clk);
    rxd = 1'b1;
    repeat (cpb) @(negedge clk);
  endtask

  task automatic end_test(input string name);
    // the checker sees the last ack on the next rising edge
    @(negedge clk);
    $display("test %s: %0d errors", name, n_errors - err_mark);
    err_mark = n_errors;
  endtask

  initial begin
    byte_t b;
    int    gap;
    clk      = 1'b0;
    rst      = 1'b1;
    rxd      = 1'b1;
    wb_req   = '0;
    lfsr     = 16'd43320;
    err_mark = 0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    // idle state, empty status, unmapped offset
    bus_read(adr_status);
    bus_read(adr_unmapped);
    end_test("after reset");
    // back-to-back writes stall on the busy serializer
    for (int i = 0; i < 20; i++) begin
      b = byte_t'(rand_bits(8));
      bus_write(adr_data, wb_dat_t'(b));
    end
    // let the checker register the last write first
    repeat (4) @(negedge clk);
    while (!tx_idle) begin
      @(negedge clk);
    end
    end_test("transmit");
    for (int i = 0; i < 20; i++) begin
      gap = int'(rand_bits(5));
      repeat (gap) @(negedge clk);
      send_frame(byte_t'(rand_bits(8)), 1'b1);
      bus_read(adr_status);
      bus_read(adr_data);
    end
    end_test("receive");
    // read stalls until the frame lands
    b = byte_t'(rand_bits(8));
    fork
      bus_read(adr_data);
      begin
        repeat (10) @(negedge clk);
        send_frame(b, 1'b1);
      end
    join
    end_test("read with empty buffer");
    send_frame(byte_t'(rand_bits(8)), 1'b1);
    send_frame(byte_t'(rand_bits(8)), 1'b1);
    bus_read(adr_data);
    bus_read(adr_status);
    bus_read(adr_status);
    end_test("overrun");
    send_frame(byte_t'(rand_bits(8)), 1'b0);
    bus_read(adr_status);
    send_frame(byte_t'(rand_bits(8)), 1'b1);
    bus_read(adr_data);
    bus_read(adr_status);
    end_test("framing error");
    repeat (10) @(negedge clk);
    $display("summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+logic
logic/uart_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/uart_periph.sv
dv/uart_checker.sv
dv/tb_uart.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_uart -f filelist.f
	./obj_dir/Vtb_uart | tee $(LOG)
	grep -q 'All tests passed!' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
